//--- dg_pkg.sv
package dg_pkg;

   // ==========================================================
   // delay/width table types
   // ==========================================================

   // one channel, delay in the upper half of the write data word
   typedef struct packed {
      logic [31:0] delay;   // clk100 cycles after t0
      logic [31:0] width;   // cycles, 0 = never active
   } delay_width_t;

   localparam int N_CHANNELS = 9;   // push, inject, eject x2, gate x2, adc, 2 spare
   localparam int N_PAGES    = 4;   // protocol pages

   typedef logic [1:0] page_t;
   typedef delay_width_t [N_CHANNELS-1:0] pair_array_t;   // one protocol page

   // ==========================================================
   // host register map
   // ==========================================================

   typedef logic [3:0] reg_addr_t;

   localparam reg_addr_t ADDR_INTERVAL   = 4'd0;    // staged interval, data[31:0]
   localparam reg_addr_t ADDR_PAIR_FIRST = 4'd1;    // channel 0
   localparam reg_addr_t ADDR_PAIR_LAST  = 4'd9;    // channel 8
   localparam reg_addr_t ADDR_PAGE       = 4'd11;   // write page, data[1:0]
   localparam reg_addr_t ADDR_PROTOCOL   = 4'd14;   // protocol number, data[1:0]
   localparam reg_addr_t ADDR_COMMIT     = 4'd15;   // commit on data[0]

   // ==========================================================
   // interval limits in clk100 cycles
   // ==========================================================

   localparam logic [31:0] DEFAULT_INTERVAL = 32'd100000;   // 1 ms
   localparam logic [31:0] MIN_INTERVAL     = 32'd1000;     // 10 us

endpackage

//--- dg_reg_decode.sv
`timescale 1ns/1ns

module dg_reg_decode
   import dg_pkg::*;
#(
   parameter logic [31:0] DEFAULT_INTERVAL = dg_pkg::DEFAULT_INTERVAL,
   parameter logic [31:0] MIN_INTERVAL     = dg_pkg::MIN_INTERVAL
) (
   input  logic        clk100,
   input  logic        hps_fpga_reset_n,
   input  logic        wr_en,
   input  reg_addr_t   wr_addr,
   input  logic [63:0] wr_data,
   output pair_array_t sel_pairs,
   output logic        commit,
   output logic [31:0] commit_interval
);

   // ==========================================================
   // host visible state
   // ==========================================================

   pair_array_t tbl [N_PAGES];    // four protocol pages
   page_t       wr_page;          // page that pair writes go to
   page_t       protocol;         // page handed to the sequencer
   logic [31:0] interval_stage;   // waits here until commit

   logic [3:0]  ch_idx;           // channel addressed by a pair write
   logic        pair_hit;
   logic        commit_hit;
   logic [31:0] interval_clamped;

   assign ch_idx   = wr_addr - ADDR_PAIR_FIRST;
   assign pair_hit = (wr_addr >= ADDR_PAIR_FIRST) && (wr_addr <= ADDR_PAIR_LAST);

   assign commit_hit = wr_en && (wr_addr == ADDR_COMMIT) && wr_data[0];

   // short intervals are raised to the minimum
   assign interval_clamped = (interval_stage < MIN_INTERVAL) ? MIN_INTERVAL
                                                             : interval_stage;

   // ==========================================================
   // register writes
   // ==========================================================

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         tbl            <= '{default: '0};
         wr_page        <= '0;
         protocol       <= '0;
         interval_stage <= DEFAULT_INTERVAL;
      end else if (wr_en) begin
         case (wr_addr)
            ADDR_INTERVAL: begin
               interval_stage <= wr_data[31:0];
            end
            ADDR_PAGE: begin
               wr_page <= wr_data[1:0];
            end
            ADDR_PROTOCOL: begin
               protocol <= wr_data[1:0];   // takes effect at next t0
            end
            default: begin
               if (pair_hit) begin
                  tbl[wr_page][ch_idx] <= wr_data;   // {delay, width}
               end
            end
         endcase
      end
   end

   // ==========================================================
   // commit strobe
   // ==========================================================

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         commit <= 1'b0;
      end else begin
         commit <= commit_hit;   // one cycle wide
      end
   end

   // clamped interval handed over with the commit strobe
   always_ff @(posedge clk100) begin
      if (commit_hit) begin
         commit_interval <= interval_clamped;
      end
   end

   // selected page, read straight out of the table
   assign sel_pairs = tbl[protocol];

endmodule

//--- dg_sequencer.sv
`timescale 1ns/1ns

module dg_sequencer
   import dg_pkg::*;
#(
   parameter logic [31:0] DEFAULT_INTERVAL = dg_pkg::DEFAULT_INTERVAL
) (
   input  logic                  clk100,
   input  logic                  hps_fpga_reset_n,
   input  pair_array_t           sel_pairs,
   input  logic                  commit,
   input  logic [31:0]           commit_interval,
   output logic                  t0,
   output logic [N_CHANNELS-1:0] ch_active
);

   // ==========================================================
   // period counter
   // ==========================================================

   logic [31:0] interval;     // period length in clk100 cycles
   logic [31:0] phase;        // 0 .. interval-1
   logic [31:0] phase_next;
   logic        period_end;

   pair_array_t act_pairs;    // pairs held for the running period
   pair_array_t cur_pairs;    // pairs seen by the window compare

   // phase 0 marks the start of every period
   assign t0 = (phase == '0);

   assign period_end = (phase >= interval - 32'd1);

   always_comb begin
      if (commit && !t0) begin
         phase_next = '0;            // restart on new interval
      end else if (commit) begin
         phase_next = 32'd1;         // period already began this cycle
      end else if (period_end) begin
         phase_next = '0;            // wrap
      end else begin
         phase_next = phase + 32'd1;
      end
   end

   // reset parks the phase on the last count, so the first cycle
   // out of reset is phase 0 and starts the first period
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         interval <= DEFAULT_INTERVAL;
         phase    <= DEFAULT_INTERVAL - 32'd1;
      end else begin
         phase <= phase_next;
         if (commit) begin
            interval <= commit_interval;   // already clamped
         end
      end
   end

   // ==========================================================
   // per-period pair latch
   // ==========================================================

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         act_pairs <= '0;             // zero widths, all channels idle
      end else if (t0) begin
         act_pairs <= sel_pairs;      // protocol switch lands here
      end
   end

   // during phase 0 the latch is not loaded yet, use the table
   assign cur_pairs = t0 ? sel_pairs : act_pairs;

   // ==========================================================
   // channel windows
   // ==========================================================

   for (genvar i = 0; i < N_CHANNELS; i++) begin : g_win
      logic [32:0] win_end;    // one extra bit against overflow
      logic        after_start;
      logic        before_end;

      assign win_end     = {1'b0, cur_pairs[i].delay} + {1'b0, cur_pairs[i].width};
      assign after_start = (phase >= cur_pairs[i].delay);
      assign before_end  = ({1'b0, phase} < win_end);   // width 0 never passes

      assign ch_active[i] = after_start && before_end;
   end

endmodule

//--- dg_output_stage.sv
`timescale 1ns/1ns

module dg_output_stage
   import dg_pkg::*;
(
   input  logic                  clk100,
   input  logic                  hps_fpga_reset_n,
   input  logic                  t0,
   input  logic [N_CHANNELS-1:0] ch_active,
   output logic                  push_n,
   output logic                  inject_n,
   output logic                  eject_n,
   output logic                  gate_n,
   output logic                  adc_n,
   output logic                  t0_out,
   output logic [63:0]           timestamp,
   output logic [31:0]           t0_count
);

   // ==========================================================
   // pin mapping, active low
   // ==========================================================

   // channels 7 and 8 are spare and stay internal
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         push_n   <= 1'b1;
         inject_n <= 1'b1;
         eject_n  <= 1'b1;
         gate_n   <= 1'b1;
         adc_n    <= 1'b1;
         t0_out   <= 1'b0;
      end else begin
         push_n   <= ~ch_active[0];                   // push
         inject_n <= ~ch_active[1];                   // injection sector
         eject_n  <= ~(ch_active[2] | ch_active[3]);  // ejection sector 0,1
         gate_n   <= ~(ch_active[4] | ch_active[5]);  // gate 0,1
         adc_n    <= ~ch_active[6];                   // adc delay
         t0_out   <= t0;                              // aligned with the pins
      end
   end

   // ==========================================================
   // timestamp capture
   // ==========================================================

   logic [63:0] clk_count;   // free running clk100 count

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         clk_count <= '0;
         timestamp <= '0;
         t0_count  <= '0;
      end else begin
         clk_count <= clk_count + 64'd1;
         if (t0) begin
            timestamp <= clk_count;          // count at the t0 cycle
            t0_count  <= t0_count + 32'd1;
         end
      end
   end

endmodule

//--- dg_top.sv
`timescale 1ns/1ns

module dg_top
   import dg_pkg::*;
#(
   parameter logic [31:0] DEFAULT_INTERVAL = dg_pkg::DEFAULT_INTERVAL,
   parameter logic [31:0] MIN_INTERVAL     = dg_pkg::MIN_INTERVAL
) (
   input  logic        clk100,
   input  logic        hps_fpga_reset_n,
   input  logic        wr_en,
   input  reg_addr_t   wr_addr,
   input  logic [63:0] wr_data,
   output logic        push_n,
   output logic        inject_n,
   output logic        eject_n,
   output logic        gate_n,
   output logic        adc_n,
   output logic        t0_out,
   output logic [63:0] timestamp,
   output logic [31:0] t0_count
);

   pair_array_t           sel_pairs;
   logic                  commit;
   logic [31:0]           commit_interval;
   logic                  t0;
   logic [N_CHANNELS-1:0] ch_active;

   // host register writes
   dg_reg_decode #(
      .DEFAULT_INTERVAL (DEFAULT_INTERVAL),
      .MIN_INTERVAL     (MIN_INTERVAL)
   ) u_reg_decode (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .wr_en            (wr_en),
      .wr_addr          (wr_addr),
      .wr_data          (wr_data),
      .sel_pairs        (sel_pairs),
      .commit           (commit),
      .commit_interval  (commit_interval)
   );

   dg_sequencer #(
      .DEFAULT_INTERVAL (DEFAULT_INTERVAL)
   ) u_sequencer (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .sel_pairs        (sel_pairs),
      .commit           (commit),
      .commit_interval  (commit_interval),
      .t0               (t0),
      .ch_active        (ch_active)
   );

   dg_output_stage u_output_stage (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .t0               (t0),
      .ch_active        (ch_active),
      .push_n           (push_n),
      .inject_n         (inject_n),
      .eject_n          (eject_n),
      .gate_n           (gate_n),
      .adc_n            (adc_n),
      .t0_out           (t0_out),
      .timestamp        (timestamp),
      .t0_count         (t0_count)
   );

endmodule

//--- dg_props.sv
`timescale 1ns/1ns

module dg_props (
   input logic        clk100,
   input logic        hps_fpga_reset_n,
   input logic        t0,
   input logic        t0_out,
   input logic        push_n,
   input logic        inject_n,
   input logic        eject_n,
   input logic        gate_n,
   input logic        adc_n,
   input logic [63:0] timestamp
);

   int unsigned assert_fails = 0;   // failed assertion count

   // ==========================================================
   // period start
   // ==========================================================

   t0_single: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      t0 |=> !t0)
      else begin
         assert_fails++;
         $error("sequencer t0 high in two consecutive cycles");
      end

   // ==========================================================
   // pins and timestamp
   // ==========================================================

   pins_idle_in_reset: assert property (@(posedge clk100)
      !hps_fpga_reset_n |=> (push_n && inject_n && eject_n && gate_n && adc_n))
      else begin
         assert_fails++;
         $error("output pin low while reset is asserted");
      end

   stamp_on_t0: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      !$stable(timestamp) |-> t0_out)
      else begin
         assert_fails++;
         $error("timestamp changed outside a t0_out cycle");
      end

endmodule

bind dg_top dg_props u_props (
   .clk100           (clk100),
   .hps_fpga_reset_n (hps_fpga_reset_n),
   .t0               (t0),   // sequencer t0 inside dg_top
   .t0_out           (t0_out),
   .push_n           (push_n),
   .inject_n         (inject_n),
   .eject_n          (eject_n),
   .gate_n           (gate_n),
   .adc_n            (adc_n),
   .timestamp        (timestamp)
);

//--- dg_tb.sv
`timescale 1ns/1ns

module dg_tb
   import dg_pkg::*;
();

   localparam logic [31:0] MIN_CYCLES     = 32'd1000;
   localparam logic [31:0] DEFAULT_CYCLES = 32'd100000;
   localparam int          TIMEOUT_CYCLES = 60000;   // ~30 periods of 1000 to 2000 cycles
   localparam logic [31:0] RAND_SEED      = 32'h7134b366;

   logic        clk100 = 1'b0;
   logic        hps_fpga_reset_n;
   logic        wr_en;
   reg_addr_t   wr_addr;
   logic [63:0] wr_data;
   logic        push_n;
   logic        inject_n;
   logic        eject_n;
   logic        gate_n;
   logic        adc_n;
   logic        t0_out;
   logic [63:0] timestamp;
   logic [31:0] t0_count;

   int          cyc = 0;         // clk100 edges since start
   int          t0_cyc;          // cycle of the last t0_out
   int          n_checks = 0;
   int          n_err = 0;
   int          err_mark;
   string       test_name;

   // expected state, kept from the register writes
   pair_array_t model_tbl [N_PAGES];
   page_t       mdl_page;
   page_t       mdl_protocol;
   logic [31:0] mdl_interval;
   pair_array_t exp_pairs;       // pairs of the running period
   int          pin_low [5];     // low cycles per pin in this period
   logic        scan_bad;
   string       pin_name [5] = '{"push_n", "inject_n", "eject_n", "gate_n", "adc_n"};

   dg_top #(
      .DEFAULT_INTERVAL (DEFAULT_CYCLES),
      .MIN_INTERVAL     (MIN_CYCLES)
   ) dut (
      .clk100           (clk100),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .wr_en            (wr_en),
      .wr_addr          (wr_addr),
      .wr_data          (wr_data),
      .push_n           (push_n),
      .inject_n         (inject_n),
      .eject_n          (eject_n),
      .gate_n           (gate_n),
      .adc_n            (adc_n),
      .t0_out           (t0_out),
      .timestamp        (timestamp),
      .t0_count         (t0_count)
   );

   always #5 clk100 = ~clk100;   // 100 MHz

   always @(posedge clk100) begin
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, test %s did not finish", cyc, test_name);
         $display("CHECKS FAILED");
         $finish;
      end else begin
         cyc <= cyc + 1;
      end
   end

   // ==========================================================
   // compare tasks
   // ==========================================================

   task automatic check_bit(input string name, input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         n_err++;
         $display("FAILED %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      n_checks++;
      if (act !== exp) begin
         n_err++;
         $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_stamp(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      n_checks++;
      if (act !== exp) begin
         n_err++;
         $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_mark  = n_err;
   endtask

   task automatic end_test();
      $display("test %-10s done, %0d errors", test_name, n_err - err_mark);
   endtask

   // ==========================================================
   // host writes
   // ==========================================================

   task automatic write_reg(input reg_addr_t addr, input logic [63:0] data);
      @(posedge clk100);
      #1;
      wr_en   = 1'b1;
      wr_addr = addr;
      wr_data = data;
      @(posedge clk100);
      #1;
      wr_en   = 1'b0;
   endtask

   task automatic set_page(input page_t p);
      write_reg(ADDR_PAGE, 64'(p));
      mdl_page = p;
   endtask

   task automatic select_protocol(input page_t p);
      write_reg(ADDR_PROTOCOL, 64'(p));
      mdl_protocol = p;   // outputs follow at the next t0
   endtask

   task automatic write_pair(input int ch, input logic [31:0] delay,
                             input logic [31:0] width);
      delay_width_t pair;
      pair.delay = delay;
      pair.width = width;
      write_reg(reg_addr_t'(ADDR_PAIR_FIRST + ch), pair);
      model_tbl[mdl_page][ch] = pair;
   endtask

   // ==========================================================
   // period tracking and pin scan
   // ==========================================================

   task automatic wait_t0();
      @(negedge clk100);
      while (t0_out !== 1'b1) begin
         @(negedge clk100);
      end
      t0_cyc    = cyc;
      exp_pairs = model_tbl[mdl_protocol];   // latched at period start
      pin_low   = '{default: 0};
      scan_bad  = 1'b0;
   endtask

   // commit, then land on the first t0_out of the new interval
   task automatic apply_interval(input logic [31:0] value);
      write_reg(ADDR_INTERVAL, 64'(value));
      write_reg(ADDR_COMMIT, 64'd1);
      mdl_interval = (value < MIN_CYCLES) ? MIN_CYCLES : value;
      @(negedge clk100);   // may still show the old period's t0_out
      wait_t0();
   endtask

   task automatic check_pins();
      longint                off;
      longint                d;
      longint                w;
      logic [N_CHANNELS-1:0] act;
      logic [4:0]            exp_pin;   // adc, gate, eject, inject, push
      logic [4:0]            dut_pin;
      off = cyc - t0_cyc;
      for (int i = 0; i < N_CHANNELS; i++) begin
         d      = exp_pairs[i].delay;
         w      = exp_pairs[i].width;
         act[i] = (off >= d) && (off < d + w);
      end
      exp_pin = {~act[6], ~(act[4] | act[5]), ~(act[2] | act[3]), ~act[1], ~act[0]};
      dut_pin = {adc_n, gate_n, eject_n, inject_n, push_n};
      for (int j = 0; j < 5; j++) begin
         if (dut_pin[j] === 1'b0) begin
            pin_low[j]++;
         end
      end
      if (!scan_bad) begin
         for (int j = 0; j < 5; j++) begin
            check_bit($sformatf("%s %s at phase %0d", test_name, pin_name[j], off),
                      exp_pin[j], dut_pin[j]);
         end
         check_bit($sformatf("%s t0_out at phase %0d", test_name, off),
                   (off == 0), t0_out);
         if ((dut_pin !== exp_pin) || (t0_out !== (off == 0))) begin
            scan_bad = 1'b1;
         end
      end
   endtask

   task automatic scan_to(input int last_off);
      while ((cyc - t0_cyc) < last_off) begin
         @(negedge clk100);
         check_pins();
      end
   endtask

   task automatic scan_period();
      check_pins();
      scan_to(mdl_interval - 1);
   endtask

   task automatic check_idle();
      logic [4:0] pins;   // adc, gate, eject, inject, push
      pins = {adc_n, gate_n, eject_n, inject_n, push_n};
      for (int j = 0; j < 5; j++) begin
         check_bit({test_name, " ", pin_name[j]}, 1'b1, pins[j]);
      end
      check_bit({test_name, " t0_out"}, 1'b0, t0_out);
      check_count({test_name, " t0_count"}, 32'd0, t0_count);
   endtask

   // ==========================================================
   // tests
   // ==========================================================

   task automatic test_reset();
      begin_test("reset");
      repeat (7) begin
         @(negedge clk100);
         check_idle();
      end
      @(posedge clk100);
      #1 hps_fpga_reset_n = 1'b1;   // eight edges with reset low
      @(negedge clk100);
      while (t0_out !== 1'b1) begin
         check_idle();
         @(negedge clk100);
      end
      t0_cyc = cyc;
      check_count("reset t0_count after first t0", 32'd1, t0_count);
      end_test();
   endtask

   task automatic test_commit_clamp();
      int t_first;
      begin_test("commit");
      apply_interval(32'd2000);
      t_first = t0_cyc;
      wait_t0();
      check_count("commit 2000 spacing", 32'd2000, 32'(t0_cyc - t_first));
      apply_interval(32'd500);
      t_first = t0_cyc;
      wait_t0();
      check_count("commit 500 clamped spacing", 32'd1000, 32'(t0_cyc - t_first));
      end_test();
   endtask

   task automatic test_window();
      int unsigned d;
      begin_test("window");
      d = $urandom % 800;
      wait_t0();
      set_page(2'd0);
      write_pair(0, d, 32'd50);
      wait_t0();
      scan_period();
      check_count("window push_n low cycles", 32'd50, pin_low[0]);
      wait_t0();
      write_pair(0, d, 32'd0);   // width 0, channel off
      wait_t0();
      scan_period();
      check_count("window width 0 push_n low cycles", 32'd0, pin_low[0]);
      end_test();
   endtask

   task automatic test_or_map();
      begin_test("or_map");
      wait_t0();
      write_pair(2, 32'd100, 32'd40);
      write_pair(3, 32'd300, 32'd60);
      write_pair(4, 32'd0, 32'd0);
      write_pair(5, 32'd0, 32'd0);
      write_pair(6, 32'd500, 32'd20);
      write_pair(7, 32'd700, 32'd50);   // spare, no pin
      wait_t0();
      scan_period();
      check_count("or_map eject_n low cycles", 32'd100, pin_low[2]);
      check_count("or_map gate_n low cycles", 32'd0, pin_low[3]);
      check_count("or_map adc_n low cycles", 32'd20, pin_low[4]);
      end_test();
   endtask

   task automatic test_protocol_switch();
      begin_test("protocol");
      wait_t0();
      write_pair(1, 32'd200, 32'd30);   // page 0
      set_page(2'd1);
      write_pair(1, 32'd600, 32'd30);   // page 1
      set_page(2'd0);
      wait_t0();
      check_pins();
      scan_to(400);
      select_protocol(2'd1);   // mid-period
      scan_to(mdl_interval - 1);
      check_count("protocol old inject_n low cycles", 32'd30, pin_low[1]);
      wait_t0();
      scan_period();
      check_count("protocol new inject_n low cycles", 32'd30, pin_low[1]);
      end_test();
   endtask

   task automatic test_timestamp();
      logic [63:0] ts_prev;
      logic [31:0] cnt_prev;
      begin_test("timestamp");
      wait_t0();
      ts_prev  = timestamp;
      cnt_prev = t0_count;
      repeat (3) begin
         wait_t0();
         check_stamp("timestamp step", 64'(mdl_interval), timestamp - ts_prev);
         check_count("timestamp t0_count step", 32'd1, t0_count - cnt_prev);
         ts_prev  = timestamp;
         cnt_prev = t0_count;
      end
      end_test();
   endtask

   initial begin
      int unsigned seed_dummy;
      hps_fpga_reset_n = 1'b0;
      wr_en            = 1'b0;
      wr_addr          = '0;
      wr_data          = '0;
      seed_dummy       = $urandom(RAND_SEED);
      model_tbl        = '{default: '0};
      exp_pairs        = '0;
      mdl_page         = '0;
      mdl_protocol     = '0;
      mdl_interval     = DEFAULT_CYCLES;
      scan_bad         = 1'b0;
      test_name        = "init";

      test_reset();
      test_commit_clamp();
      test_window();
      test_or_map();
      test_protocol_switch();
      test_timestamp();

      n_err += dut.u_props.assert_fails;
      $display("%0d checks, %0d errors", n_checks, n_err);
      if (n_err == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- sources.f
dg_pkg.sv
dg_reg_decode.sv
dg_sequencer.sv
dg_output_stage.sv
dg_top.sv
dg_props.sv
dg_tb.sv

//--- Bender.yml
package:
  name: dg_pulse_gen

dependencies: {}

sources:
  - dg_pkg.sv
  - dg_reg_decode.sv
  - dg_sequencer.sv
  - dg_output_stage.sv
  - dg_top.sv
  - target: test
    files:
      - dg_props.sv
      - dg_tb.sv
